// File: sources.f
common/rv_pkg.sv
decode/imm_extractor.sv
decode/rv_decoder.sv
verilog/reg_file.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core_top.sv
bench/tb_rv_core.sv

// File: Makefile
SOURCES := $(shell cat sources.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_rv_core: sources.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_core -f sources.f

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core

clean:
	rm -rf obj_dir

// File: bench/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    // Tests run about 170 cycles
    localparam int max_cycles = 400;

    logic             clk = 1'b0;
    logic             reset = 1'b1;
    logic             instr_valid = 1'b0;
    word_t            instr = '0;
    word_t            pc = '0;
    logic             wb_valid;
    reg_idx_t         wb_rd;
    word_t            wb_data;
    logic             redirect_valid;
    word_t            redirect_pc;
    logic             store_valid;
    word_t            store_addr;
    word_t            store_data;
    logic [2:0]       store_size;
    logic             illegal;

    word_t model_regs [32];
    word_t cur_pc = 32'h0000_0100;
    int    cycles = 0;

    rv_core_top #(
        .num_regs(32)
    ) i_dut (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr(instr),
        .pc(pc),
        .wb_valid(wb_valid),
        .wb_rd(wb_rd),
        .wb_data(wb_data),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc),
        .store_valid(store_valid),
        .store_addr(store_addr),
        .store_data(store_data),
        .store_size(store_size),
        .illegal(illegal)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Timeout, the run went past %0d cycles", max_cycles);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    // Instruction encoders
    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_op};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic word_t enc_u(input logic [19:0] upper, input reg_idx_t rd,
                                    input opcode_t op);
        return {upper, rd, op};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I arithmetic where alt selects sub and sra
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]))
                             : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a,
                                          input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            stop_on_error($sformatf("** Error: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            if (exp)
                stop_on_error($sformatf("%s did not rise one cycle after issue", name));
            else
                stop_on_error($sformatf("%s rose although no such outcome was due", name));
        end
    endtask

    task automatic expect_strobes(input logic wb, input logic redir, input logic st,
                                  input logic ill);
        check_strobe("wb_valid", wb_valid, wb);
        check_strobe("redirect_valid", redirect_valid, redir);
        check_strobe("store_valid", store_valid, st);
        check_strobe("illegal", illegal, ill);
    endtask

    task automatic check_wb(input reg_idx_t rd, input word_t exp);
        compare_value("wb_rd", 32'(wb_rd), 32'(rd));
        compare_value("wb_data", wb_data, exp);
    endtask

    task automatic check_redirect(input word_t target);
        compare_value("redirect_pc", redirect_pc, target);
    endtask

    task automatic check_store(input word_t addr, input word_t data, input logic [2:0] size);
        compare_value("store_addr", store_addr, addr);
        compare_value("store_data", store_data, data);
        compare_value("store_size", 32'(store_size), 32'(size));
    endtask

    task automatic check_illegal();
        expect_strobes(1'b0, 1'b0, 1'b0, 1'b1);
    endtask

    // Outputs are stable at the falling edge after the capture edge
    task automatic issue(input word_t word);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr <= word;
        pc <= cur_pc;
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic run_alu(input word_t word, input reg_idx_t rd, input word_t exp);
        issue(word);
        expect_strobes(rd != 5'd0, 1'b0, 1'b0, 1'b0);
        if (rd != 5'd0)
        begin
            check_wb(rd, exp);
            model_regs[rd] = exp;
        end
    endtask

    task automatic load_reg(input reg_idx_t rd, input word_t val);
        logic [19:0] upper;
        upper = val[31:12] + {19'd0, val[11]};
        run_alu(enc_u(upper, rd, op_lui), rd, {upper, 12'd0});
        run_alu(enc_i(val[11:0], rd, 3'd0, rd, op_op_imm), rd,
                alu_model(3'd0, 1'b0, model_regs[rd], sext12(val[11:0])));
    endtask

    task automatic run_jump(input word_t word, input reg_idx_t rd, input word_t target);
        word_t link;
        link = cur_pc + 32'd4;
        issue(word);
        expect_strobes(rd != 5'd0, 1'b1, 1'b0, 1'b0);
        if (rd != 5'd0)
        begin
            check_wb(rd, link);
            model_regs[rd] = link;
        end
        check_redirect(target);
    endtask

    task automatic run_branch(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2);
        logic [12:0] off;
        logic        taken;
        word_t       target;
        off = {12'($urandom), 1'b0};
        taken = branch_model(f3, model_regs[rs1], model_regs[rs2]);
        target = cur_pc + {{19{off[12]}}, off};
        issue(enc_b(off, rs2, rs1, f3));
        expect_strobes(1'b0, taken, 1'b0, 1'b0);
        if (taken)
        begin
            check_redirect(target);
        end
    endtask

    task automatic test_reset_state();
        expect_strobes(1'b0, 1'b0, 1'b0, 1'b0);
        run_alu(enc_i(12'd0, 5'd0, 3'd0, 5'd5, op_op_imm), 5'd5, 32'd0);
        run_alu(enc_r(7'd0, 5'd8, 5'd7, 3'd0, 5'd6), 5'd6, 32'd0);
    endtask

    task automatic test_alu_ops();
        logic [11:0] imm;
        logic [4:0]  shamt;
        for (int r = 1; r <= 8; r++)
        begin
            load_reg(5'(r), $urandom);
        end
        // Negative operands for sra and sltu
        load_reg(5'd3, $urandom | 32'h8000_0000);
        load_reg(5'd4, $urandom | 32'h8000_0000);
        for (int f3 = 0; f3 < 8; f3++)
        begin
            run_alu(enc_r(7'd0, 5'd3, 5'd1, 3'(f3), 5'd10), 5'd10,
                    alu_model(3'(f3), 1'b0, model_regs[1], model_regs[3]));
        end
        run_alu(enc_r(7'b0100000, 5'd3, 5'd1, 3'd0, 5'd11), 5'd11,
                alu_model(3'd0, 1'b1, model_regs[1], model_regs[3]));
        run_alu(enc_r(7'b0100000, 5'd2, 5'd4, 3'd5, 5'd11), 5'd11,
                alu_model(3'd5, 1'b1, model_regs[4], model_regs[2]));
        for (int f3 = 0; f3 < 8; f3++)
        begin
            imm = 12'($urandom);
            shamt = 5'($urandom);
            if (f3 == 1 || f3 == 5)
                run_alu(enc_i({7'd0, shamt}, 5'd4, 3'(f3), 5'd12, op_op_imm), 5'd12,
                        alu_model(3'(f3), 1'b0, model_regs[4], {27'd0, shamt}));
            else
                run_alu(enc_i(imm, 5'd4, 3'(f3), 5'd12, op_op_imm), 5'd12,
                        alu_model(3'(f3), 1'b0, model_regs[4], sext12(imm)));
        end
        // Nonzero shift so the sign fill shows
        shamt = 5'($urandom) | 5'd1;
        run_alu(enc_i({7'b0100000, shamt}, 5'd4, 3'd5, 5'd12, op_op_imm), 5'd12,
                alu_model(3'd5, 1'b1, model_regs[4], {27'd0, shamt}));
        // Minus five must sign-extend
        run_alu(enc_i(12'hffb, 5'd2, 3'd0, 5'd13, op_op_imm), 5'd13, model_regs[2] - 32'd5);
        run_alu(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd0), 5'd0, 32'd0);
        run_alu(enc_i(12'd0, 5'd0, 3'd0, 5'd14, op_op_imm), 5'd14, 32'd0);
    endtask

    task automatic test_jumps_branches();
        logic [19:0] upper;
        logic [20:0] joff;
        logic [11:0] imm;
        logic [2:0]  conds [6];
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        cur_pc = {18'd0, 12'($urandom), 2'b00};
        upper = 20'($urandom);
        run_alu(enc_u(upper, 5'd15, op_auipc), 5'd15, cur_pc + {upper, 12'd0});
        joff = {20'($urandom), 1'b0};
        run_jump(enc_j(joff, 5'd16), 5'd16, cur_pc + {{11{joff[20]}}, joff});
        joff = {20'($urandom), 1'b0};
        run_jump(enc_j(joff, 5'd0), 5'd0, cur_pc + {{11{joff[20]}}, joff});
        imm = 12'($urandom);
        // Odd register sum so bit 0 has to be cleared
        imm[0] = ~model_regs[1][0];
        run_jump(enc_i(imm, 5'd1, 3'd0, 5'd17, op_jalr), 5'd17,
                 (model_regs[1] + sext12(imm)) & ~32'd1);
        run_alu(enc_i(12'd5, 5'd0, 3'd0, 5'd20, op_op_imm), 5'd20, 32'd5);
        run_alu(enc_i(12'd5, 5'd0, 3'd0, 5'd21, op_op_imm), 5'd21, 32'd5);
        run_alu(enc_i(12'hffd, 5'd0, 3'd0, 5'd22, op_op_imm), 5'd22, 32'hffff_fffd);
        run_alu(enc_i(12'd7, 5'd0, 3'd0, 5'd23, op_op_imm), 5'd23, 32'd7);
        // Pairs give each condition a taken and a not-taken case
        for (int c = 0; c < 6; c++)
        begin
            run_branch(conds[c], 5'd20, 5'd21);
            run_branch(conds[c], 5'd20, 5'd23);
            run_branch(conds[c], 5'd22, 5'd23);
            run_branch(conds[c], 5'd23, 5'd22);
        end
    endtask

    task automatic test_stores();
        logic [11:0] imm;
        word_t       data;
        for (int sz = 0; sz < 3; sz++)
        begin
            imm = 12'($urandom);
            if (sz == 0)
                data = {24'd0, model_regs[2][7:0]};
            else if (sz == 1)
                data = {16'd0, model_regs[2][15:0]};
            else
                data = model_regs[2];
            issue(enc_s(imm, 5'd2, 5'd1, 3'(sz)));
            expect_strobes(1'b0, 1'b0, 1'b1, 1'b0);
            check_store(model_regs[1] + sext12(imm), data, 3'(sz));
        end
    endtask

    task automatic test_illegal();
        // Load opcode is outside the slice
        issue({12'd4, 5'd2, 3'd2, 5'd1, 7'b0000011});
        check_illegal();
        issue(enc_r(7'b0000001, 5'd2, 5'd3, 3'd0, 5'd1));
        check_illegal();
        run_alu(enc_i(12'd0, 5'd1, 3'd0, 5'd18, op_op_imm), 5'd18, model_regs[1]);
    endtask

    initial
    begin
        void'($urandom(32'h8b64_8979));
        for (int i = 0; i < 32; i++)
        begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_reset_state();
        test_alu_ops();
        test_jumps_branches();
        test_stores();
        test_illegal();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/rv_core_top.sv
`default_nettype none

module rv_core_top #(
    parameter int num_regs = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_valid,
    input  rv_pkg::word_t    instr,
    input  rv_pkg::word_t    pc,
    output logic             wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data,
    output logic             redirect_valid,
    output rv_pkg::word_t    redirect_pc,
    output logic             store_valid,
    output rv_pkg::word_t    store_addr,
    output rv_pkg::word_t    store_data,
    output logic [2:0]       store_size,
    output logic             illegal
);

    import rv_pkg::*;

    localparam int idx_w = $clog2(num_regs);

    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    imm_type_t    imm_type;
    alu_op_t      alu_op;
    op_a_sel_t    op_a_sel;
    op_b_sel_t    op_b_sel;
    instr_class_t instr_class;
    logic [2:0]   funct3;
    word_t        imm;
    word_t        rs1_data;
    word_t        rs2_data;
    word_t        ex_result;
    logic         ex_taken;
    word_t        ex_target;
    word_t        ex_store_addr;
    word_t        ex_store_data;
    logic         wr_en;
    logic [idx_w-1:0] wr_idx;
    word_t        wr_data;

    rv_decoder #(
        .num_regs(num_regs)
    ) i_decoder (
        .instr(instr),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .imm_type(imm_type),
        .alu_op(alu_op),
        .op_a_sel(op_a_sel),
        .op_b_sel(op_b_sel),
        .instr_class(instr_class),
        .funct3(funct3)
    );

    imm_extractor i_imm (
        .instr(instr),
        .imm_type(imm_type),
        .imm(imm)
    );

    reg_file #(
        .num_regs(num_regs)
    ) i_reg_file (
        .clk(clk),
        .reset(reset),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data)
    );

    rv_execute i_execute (
        .pc(pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .imm(imm),
        .alu_op(alu_op),
        .op_a_sel(op_a_sel),
        .op_b_sel(op_b_sel),
        .instr_class(instr_class),
        .funct3(funct3),
        .result(ex_result),
        .redirect_taken(ex_taken),
        .redirect_pc(ex_target),
        .store_addr(ex_store_addr),
        .store_data(ex_store_data)
    );

    rv_result #(
        .num_regs(num_regs)
    ) i_result (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr_class(instr_class),
        .rd(rd),
        .result(ex_result),
        .redirect_taken(ex_taken),
        .ex_redirect_pc(ex_target),
        .ex_store_addr(ex_store_addr),
        .ex_store_data(ex_store_data),
        .funct3(funct3),
        .wb_valid(wb_valid),
        .wb_rd(wb_rd),
        .wb_data(wb_data),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc),
        .store_valid(store_valid),
        .store_addr(store_addr),
        .store_data(store_data),
        .store_size(store_size),
        .illegal(illegal),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data)
    );

endmodule

`default_nettype wire

// File: verilog/rv_result.sv
`default_nettype none

module rv_result #(
    parameter int num_regs = 32
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  rv_pkg::instr_class_t        instr_class,
    input  rv_pkg::reg_idx_t            rd,
    input  rv_pkg::word_t               result,
    input  logic                        redirect_taken,
    input  rv_pkg::word_t               ex_redirect_pc,
    input  rv_pkg::word_t               ex_store_addr,
    input  rv_pkg::word_t               ex_store_data,
    input  logic [2:0]                  funct3,
    output logic                        wb_valid,
    output rv_pkg::reg_idx_t            wb_rd,
    output rv_pkg::word_t               wb_data,
    output logic                        redirect_valid,
    output rv_pkg::word_t               redirect_pc,
    output logic                        store_valid,
    output rv_pkg::word_t               store_addr,
    output rv_pkg::word_t               store_data,
    output logic [2:0]                  store_size,
    output logic                        illegal,
    output logic                        wr_en,
    output logic [$clog2(num_regs)-1:0] wr_idx,
    output rv_pkg::word_t               wr_data
);

    import rv_pkg::*;

    localparam int idx_w = $clog2(num_regs);

    logic writes_rd;

    assign writes_rd = (instr_class == cls_alu || instr_class == cls_jump) && rd != '0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
            store_valid    <= 1'b0;
            illegal        <= 1'b0;
        end
        else
        begin
            wb_valid       <= instr_valid && writes_rd;
            redirect_valid <= instr_valid && redirect_taken;
            store_valid    <= instr_valid && instr_class == cls_store;
            illegal        <= instr_valid && instr_class == cls_illegal;
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid)
        begin
            wb_rd       <= rd;
            wb_data     <= result;
            redirect_pc <= ex_redirect_pc;
            store_addr  <= ex_store_addr;
            store_data  <= ex_store_data;
            store_size  <= funct3;
        end
    end

    // Register file takes the writeback one edge later
    assign wr_en   = wb_valid;
    assign wr_idx  = wb_rd[idx_w-1:0];
    assign wr_data = wb_data;

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
`default_nettype none

module rv_execute (
    input  rv_pkg::word_t        pc,
    input  rv_pkg::word_t        rs1_data,
    input  rv_pkg::word_t        rs2_data,
    input  rv_pkg::word_t        imm,
    input  rv_pkg::alu_op_t      alu_op,
    input  rv_pkg::op_a_sel_t    op_a_sel,
    input  rv_pkg::op_b_sel_t    op_b_sel,
    input  rv_pkg::instr_class_t instr_class,
    input  logic [2:0]           funct3,
    output rv_pkg::word_t        result,
    output logic                 redirect_taken,
    output rv_pkg::word_t        redirect_pc,
    output rv_pkg::word_t        store_addr,
    output rv_pkg::word_t        store_data
);

    import rv_pkg::*;

    word_t a;
    word_t b;
    word_t alu_out;
    logic  cond;

    assign a = (op_a_sel == sel_a_pc) ? pc : rs1_data;
    assign b = (op_b_sel == sel_b_imm) ? imm : rs2_data;

    always_comb
    begin
        case (alu_op)
            alu_add:    alu_out = a + b;
            alu_sub:    alu_out = a - b;
            alu_sll:    alu_out = a << b[4:0];
            alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   alu_out = {{(xlen-1){1'b0}}, a < b};
            alu_xor:    alu_out = a ^ b;
            alu_srl:    alu_out = a >> b[4:0];
            alu_sra:    alu_out = word_t'($signed(a) >>> b[4:0]);
            alu_or:     alu_out = a | b;
            alu_and:    alu_out = a & b;
            alu_pass_b: alu_out = b;
            default:    alu_out = '0;
        endcase
    end

    // Branch compare works on the registers, the adder forms the target
    always_comb
    begin
        case (funct3)
            f3_beq:  cond = rs1_data == rs2_data;
            f3_bne:  cond = rs1_data != rs2_data;
            f3_blt:  cond = $signed(rs1_data) < $signed(rs2_data);
            f3_bge:  cond = $signed(rs1_data) >= $signed(rs2_data);
            f3_bltu: cond = rs1_data < rs2_data;
            f3_bgeu: cond = rs1_data >= rs2_data;
            default: cond = 1'b0;
        endcase
    end

    assign result = (instr_class == cls_jump) ? pc + 32'd4 : alu_out;

    assign redirect_taken = (instr_class == cls_jump)
                         || (instr_class == cls_branch && cond);

    // jalr drops bit 0 of the register based target
    assign redirect_pc = (op_a_sel == sel_a_reg) ? {alu_out[xlen-1:1], 1'b0} : alu_out;

    assign store_addr = alu_out;

    always_comb
    begin
        case (funct3)
            size_byte: store_data = {24'd0, rs2_data[7:0]};
            size_half: store_data = {16'd0, rs2_data[15:0]};
            default:   store_data = rs2_data;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`default_nettype none

module reg_file #(
    parameter int num_regs = 32
) (
    input  logic                        clk,
    input  logic                        reset,
    input  rv_pkg::reg_idx_t            rs1,
    input  rv_pkg::reg_idx_t            rs2,
    output rv_pkg::word_t               rs1_data,
    output rv_pkg::word_t               rs2_data,
    input  logic                        wr_en,
    input  logic [$clog2(num_regs)-1:0] wr_idx,
    input  rv_pkg::word_t               wr_data
);

    import rv_pkg::*;

    localparam int idx_w = $clog2(num_regs);

    word_t regs [num_regs];

    // x0 and indices past the file read as zero
    assign rs1_data = (rs1 == '0 || int'(rs1) >= num_regs) ? '0 : regs[rs1[idx_w-1:0]];
    assign rs2_data = (rs2 == '0 || int'(rs2) >= num_regs) ? '0 : regs[rs2[idx_w-1:0]];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < num_regs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && wr_idx != '0)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: decode/rv_decoder.sv
`default_nettype none

module rv_decoder #(
    parameter int num_regs = 32
) (
    input  rv_pkg::word_t        instr,
    output rv_pkg::reg_idx_t     rs1,
    output rv_pkg::reg_idx_t     rs2,
    output rv_pkg::reg_idx_t     rd,
    output rv_pkg::imm_type_t    imm_type,
    output rv_pkg::alu_op_t      alu_op,
    output rv_pkg::op_a_sel_t    op_a_sel,
    output rv_pkg::op_b_sel_t    op_b_sel,
    output rv_pkg::instr_class_t instr_class,
    output logic [2:0]           funct3
);

    import rv_pkg::*;

    logic [6:0]   funct7;
    instr_class_t cls;
    logic         uses_rs1;
    logic         uses_rs2;
    logic         uses_rd;
    logic         bad_index;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // RV32E has only sixteen registers
    assign bad_index = (uses_rs1 && int'(rs1) >= num_regs)
                    || (uses_rs2 && int'(rs2) >= num_regs)
                    || (uses_rd && int'(rd) >= num_regs);

    assign instr_class = bad_index ? cls_illegal : cls;

    always_comb
    begin
        imm_type = imm_none;
        alu_op   = alu_add;
        op_a_sel = sel_a_reg;
        op_b_sel = sel_b_reg;
        cls      = cls_illegal;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        uses_rd  = 1'b0;
        case (opcode_t'(instr[6:0]))
            op_lui:
            begin
                imm_type = imm_u;
                alu_op   = alu_pass_b;
                op_b_sel = sel_b_imm;
                uses_rd  = 1'b1;
                cls      = cls_alu;
            end
            op_auipc:
            begin
                imm_type = imm_u;
                op_a_sel = sel_a_pc;
                op_b_sel = sel_b_imm;
                uses_rd  = 1'b1;
                cls      = cls_alu;
            end
            // Target comes from the adder, link value from execute
            op_jal:
            begin
                imm_type = imm_j;
                op_a_sel = sel_a_pc;
                op_b_sel = sel_b_imm;
                uses_rd  = 1'b1;
                cls      = cls_jump;
            end
            op_jalr:
            begin
                imm_type = imm_i;
                op_b_sel = sel_b_imm;
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
                cls      = (funct3 == 3'b000) ? cls_jump : cls_illegal;
            end
            op_branch:
            begin
                imm_type = imm_b;
                op_a_sel = sel_a_pc;
                op_b_sel = sel_b_imm;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                cls      = (funct3[2:1] == 2'b01) ? cls_illegal : cls_branch;
            end
            op_store:
            begin
                imm_type = imm_s;
                op_b_sel = sel_b_imm;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                cls      = (funct3 <= size_word) ? cls_store : cls_illegal;
            end
            op_op_imm, op_op:
            begin
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
                if (instr[5])
                begin
                    uses_rs2 = 1'b1;
                end
                else
                begin
                    op_b_sel = sel_b_imm;
                    imm_type = (funct3[1:0] == 2'b01) ? imm_shamt : imm_i;
                end
                cls = cls_alu;
                case (funct3)
                    3'd0: alu_op = (instr[5] && funct7[5]) ? alu_sub : alu_add;
                    3'd1: alu_op = alu_sll;
                    3'd2: alu_op = alu_slt;
                    3'd3: alu_op = alu_sltu;
                    3'd4: alu_op = alu_xor;
                    3'd5: alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'd6: alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
                // funct7 only matters for OP and for immediate shifts
                if (instr[5] || funct3[1:0] == 2'b01)
                begin
                    if (funct7 == 7'b0100000)
                    begin
                        if (funct3 != 3'd5 && !(instr[5] && funct3 == 3'd0))
                        begin
                            cls = cls_illegal;
                        end
                    end
                    else if (funct7 != 7'b0000000)
                    begin
                        cls = cls_illegal;
                    end
                end
            end
            default:
            begin
                cls = cls_illegal;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: decode/imm_extractor.sv
`default_nettype none

module imm_extractor (
    input  rv_pkg::word_t     instr,
    input  rv_pkg::imm_type_t imm_type,
    output rv_pkg::word_t     imm
);

    import rv_pkg::*;

    logic sign;

    // Bit 31 carries the sign in every signed format
    assign sign = instr[31];

    always_comb
    begin
        case (imm_type)
            // Loads of ALU immediates and jalr
            imm_i:
            begin
                imm = {{20{sign}}, instr[31:20]};
            end
            // Branch offset, always even
            imm_b:
            begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            imm_s:
            begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            // Upper twenty bits, low bits zero
            imm_u:
            begin
                imm = {instr[31:12], 12'd0};
            end
            // Jump offset for jal only
            imm_j:
            begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            imm_shamt:
            begin
                imm = {27'd0, instr[24:20]};
            end
            default:
            begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // Immediate formats, code 6 is unused
    typedef enum logic [2:0] {
        imm_i     = 3'b000,
        imm_b     = 3'b001,
        imm_s     = 3'b010,
        imm_u     = 3'b011,
        imm_j     = 3'b100,
        imm_shamt = 3'b101,
        imm_none  = 3'b111
    } imm_type_t;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_store  = 7'b0100011,
        op_op_imm = 7'b0010011,
        op_op     = 7'b0110011
    } opcode_t;

    typedef enum logic {
        sel_a_reg = 1'b0,
        sel_a_pc  = 1'b1
    } op_a_sel_t;

    typedef enum logic {
        sel_b_reg = 1'b0,
        sel_b_imm = 1'b1
    } op_b_sel_t;

    typedef enum logic [2:0] {
        cls_alu     = 3'd0,
        cls_jump    = 3'd1,
        cls_branch  = 3'd2,
        cls_store   = 3'd3,
        cls_illegal = 3'd4
    } instr_class_t;

    // Branch conditions in funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Store sizes in funct3
    localparam logic [2:0] size_byte = 3'b000;
    localparam logic [2:0] size_half = 3'b001;
    localparam logic [2:0] size_word = 3'b010;

endpackage

`default_nettype wire
